/* build.f */
logic/core_pkg.sv
logic/mem_bus_pkg.sv
logic/fetch_unit.sv
logic/icache.sv
logic/instr_predecode.sv
logic/fetch_top.sv
tests/mem_model.sv
tests/fetch_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the fetch front end with its testbench and run the simulation
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --timescale 1ns/1ps --top-module fetch_tb -f build.f

# $fatal ends the simulation with a nonzero status, the report lines tell the result
sim_out="$(./obj_dir/Vfetch_tb 2>&1)" || true
echo "$sim_out"

if grep -qx "PASS: all tests" <<< "$sim_out"; then
    exit 0
else
    exit 1
fi

/* tests/fetch_tb.sv */
/*
 * Testbench for the instruction fetch front end.
 * Applies a table of next-pc rows, releases each held word with id_en and
 * checks the held word, predecode, pc and memory traffic per row.
 */
`timescale 1ns/1ps

module fetch_tb;
    import core_pkg::*;
    import mem_bus_pkg::*;

    localparam xlen_t RESET_PC   = 64'h8000_0000;
    localparam int    NUM_LINES  = 16;
    localparam int    NUM_ROWS   = 18;
    localparam int    CLK_PERIOD = 10;

    // one stimulus row with its expected word and predecode
    typedef struct packed {
        xlen_t      dnpc;
        logic       block;
        logic       hit;
        instr_t     instr;
        predecode_t pd;
    } row_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        dnpc_valid;
    xlen_t       dnpc;
    logic        block;
    logic        id_en;
    mem_resp_t   mem_resp;
    mem_req_t    mem_req;
    xlen_t       pc;
    fetch_resp_t fetch_resp;
    predecode_t  predecode;
    logic        if_busy;
    int          req_count;
    logic [63:0] last_addr;
    row_t        rows [$];

    fetch_top #(
        .RESET_PC  (RESET_PC),
        .NUM_LINES (NUM_LINES)
    ) UUT (.*);

    mem_model u_mem (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_with_failure();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_fetch(input string name, input fetch_resp_t got, input fetch_resp_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_predecode(input string name, input predecode_t got,
                                   input predecode_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_pc(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic add_row(input xlen_t a, input int blk, input int hit, input instr_t ins,
                           input instr_class_e cls, input int rd, input int rs1,
                           input int rs2, input xlen_t imm, input int used);
        row_t r;
        r.dnpc        = a;
        r.block       = (blk != 0);
        r.hit         = (hit != 0);
        r.instr       = ins;
        r.pd.cls      = cls;
        r.pd.rd       = 5'(rd);
        r.pd.rs1      = 5'(rs1);
        r.pd.rs2      = 5'(rs2);
        r.pd.imm      = imm;
        r.pd.imm_used = (used != 0);
        rows.push_back(r);
    endtask

    // watchdog sized from the row count
    initial begin
        #(NUM_ROWS * 40 * CLK_PERIOD);
        $display("watchdog expired before all rows were fetched");
        stop_with_failure();
    end

    initial begin
        row_t        r;
        fetch_resp_t exp_resp;
        fetch_resp_t prev_resp;
        xlen_t       exp_pc;
        int          count_before;
        logic        seen_busy;

        rst        = 1'b1;
        dnpc_valid = 1'b0;
        dnpc       = '0;
        block      = 1'b0;
        id_en      = 1'b0;

        // row 0 is the fetch from reset, its dnpc is not driven
        add_row(64'h80000000, 0, 0, 32'hfff00093, CLASS_ALU_IMM, 1, 0, 31, -64'd1, 1);
        add_row(64'h80000004, 0, 1, 32'h002081b3, CLASS_ALU, 3, 1, 2, 64'd0, 0);
        add_row(64'h80000008, 0, 1, 32'hff813283, CLASS_LOAD, 5, 2, 24, -64'd8, 1);
        add_row(64'h8000000c, 0, 1, 32'hfe613823, CLASS_STORE, 16, 2, 6, -64'd16, 1);
        add_row(64'h80000010, 0, 0, 32'hfe208ee3, CLASS_BRANCH, 29, 1, 2, -64'd4, 1);
        add_row(64'h8000001c, 0, 1, 32'h00000073, CLASS_SYSTEM_OR_ILLEGAL, 0, 0, 0, 64'd0, 0);
        add_row(64'h80000014, 0, 1, 32'h001000ef, CLASS_JAL, 1, 0, 1, 64'h800, 1);
        add_row(64'h80000018, 0, 1, 32'h00008067, CLASS_JALR, 0, 1, 0, 64'd0, 1);
        add_row(64'h80000020, 0, 0, 32'h800003b7, CLASS_ALU_IMM, 7, 0, 0,
                64'hffff_ffff_8000_0000, 1);
        add_row(64'h80000024, 0, 1, 32'h0014041b, CLASS_ALU_IMM, 8, 8, 1, 64'd1, 1);
        add_row(64'h80000028, 0, 1, 32'h12345497, CLASS_ALU_IMM, 9, 8, 3, 64'h1234_5000, 1);
        add_row(64'h8000002c, 0, 1, 32'h40c5853b, CLASS_ALU, 10, 11, 12, 64'd0, 0);
        // blocked strobe, the same word is fetched again
        add_row(64'h80000000, 1, 1, 32'h40c5853b, CLASS_ALU, 10, 11, 12, 64'd0, 0);
        // same index as the reset line, different tag
        add_row(64'h80000100, 0, 0, 32'h00472683, CLASS_LOAD, 13, 14, 4, 64'd4, 1);
        add_row(64'h80000104, 0, 1, 32'h0ff0000f, CLASS_SYSTEM_OR_ILLEGAL, 0, 0, 31, 64'd0, 0);
        add_row(64'h80000108, 0, 1, 32'h00019463, CLASS_BRANCH, 8, 3, 0, 64'd8, 1);
        add_row(64'h8000010c, 0, 1, 32'h0ff7f793, CLASS_ALU_IMM, 15, 15, 31, 64'hff, 1);
        add_row(64'h80000000, 0, 0, 32'hfff00093, CLASS_ALU_IMM, 1, 0, 31, -64'd1, 1);

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // first cycle out of reset
        check_pc("pc", pc, RESET_PC);
        if (fetch_resp.valid !== 1'b0 || mem_req.read !== 1'b0 || if_busy !== 1'b0) begin
            $display("valid, memory read or busy is not low in the first cycle after reset");
            stop_with_failure();
        end
        // nothing held yet, so predecode is all zero
        check_predecode("predecode", predecode, '0);

        exp_pc    = RESET_PC;
        prev_resp = '0;
        for (int i = 0; i < rows.size(); i++) begin
            r            = rows[i];
            count_before = req_count;
            if (i != 0) begin
                dnpc_valid = 1'b1;
                dnpc       = r.dnpc;
                block      = r.block;
                @(negedge clk);
                dnpc_valid = 1'b0;
                block      = 1'b0;
                if (!r.block) begin
                    exp_pc = r.dnpc;
                end
                check_pc("pc", pc, exp_pc);
                // previous word still held until decode takes it
                check_fetch("fetch_resp", fetch_resp, prev_resp);
                id_en = 1'b1;
                @(negedge clk);
                id_en = 1'b0;
            end

            // busy must show up while the fetch is outstanding
            seen_busy = 1'b0;
            while (!fetch_resp.valid) begin
                if (if_busy === 1'b1) begin
                    seen_busy = 1'b1;
                end
                @(negedge clk);
            end
            if (!seen_busy) begin
                $display("row %0d never raised if_busy while the fetch was outstanding", i);
                stop_with_failure();
            end
            if (if_busy !== 1'b0) begin
                $display("row %0d kept if_busy high with a word held", i);
                stop_with_failure();
            end

            exp_resp.valid = 1'b1;
            exp_resp.pc    = exp_pc;
            exp_resp.instr = r.instr;
            check_fetch("fetch_resp", fetch_resp, exp_resp);
            check_predecode("predecode", predecode, r.pd);
            check_pc("pc", pc, exp_pc);

            // one line read per miss, none on a hit
            if (req_count != count_before + (r.hit ? 0 : 1)) begin
                $display("row %0d made %0d memory requests, expected %0d", i,
                         req_count - count_before, r.hit ? 0 : 1);
                stop_with_failure();
            end
            if (!r.hit) begin
                check_pc("mem_req.addr", last_addr, {exp_pc[63:4], 4'h0});
            end
            prev_resp = exp_resp;
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

/* tests/mem_model.sv */
/*
 * Line memory for the fetch testbench.
 * Answers each line read from a preloaded instruction table after a
 * random latency of 1 to 4 cycles and counts the requests it has seen.
 * Runs on the falling edge so the DUT sees stable inputs.
 */
`timescale 1ns/1ps

module mem_model (
    input  logic                   clk,
    input  logic                   rst,
    input  mem_bus_pkg::mem_req_t  mem_req,
    output mem_bus_pkg::mem_resp_t mem_resp,
    output int                     req_count,
    output logic [63:0]            last_addr
);
    import mem_bus_pkg::*;

    integer seed = 18235;
    int     wait_cnt;
    logic   pending;
    logic   ready_q = 1'b0;
    line_t  data_q = '0;

    assign mem_resp.ready = ready_q;
    assign mem_resp.data  = data_q;

    // three lines from the reset pc and one line that aliases index 0
    function automatic logic [31:0] word_at(input logic [63:0] a);
        case (a)
            64'h8000_0000: word_at = 32'hfff00093;
            64'h8000_0004: word_at = 32'h002081b3;
            64'h8000_0008: word_at = 32'hff813283;
            64'h8000_000c: word_at = 32'hfe613823;
            64'h8000_0010: word_at = 32'hfe208ee3;
            64'h8000_0014: word_at = 32'h001000ef;
            64'h8000_0018: word_at = 32'h00008067;
            64'h8000_001c: word_at = 32'h00000073;
            64'h8000_0020: word_at = 32'h800003b7;
            64'h8000_0024: word_at = 32'h0014041b;
            64'h8000_0028: word_at = 32'h12345497;
            64'h8000_002c: word_at = 32'h40c5853b;
            64'h8000_0100: word_at = 32'h00472683;
            64'h8000_0104: word_at = 32'h0ff0000f;
            64'h8000_0108: word_at = 32'h00019463;
            64'h8000_010c: word_at = 32'h0ff7f793;
            // fill pattern outside the table, built from the whole address
            default:       word_at = a[31:0] ^ a[63:32] ^ 32'h6b1d_e2f3;
        endcase
    endfunction

    // word k of a line sits in bits 32k and up
    function automatic line_t read_line(input logic [63:0] base);
        line_t l;
        int    k;
        for (k = 0; k < 4; k++) begin
            l[32*k +: 32] = word_at(base + 64'(4 * k));
        end
        return l;
    endfunction

    always @(negedge clk) begin
        if (rst) begin
            ready_q   <= 1'b0;
            pending   <= 1'b0;
            wait_cnt  <= 0;
            req_count <= 0;
            last_addr <= '0;
        end else if (ready_q) begin
            // single ready beat, the cache drops read right after it
            ready_q <= 1'b0;
            pending <= 1'b0;
        end else if (pending) begin
            if (wait_cnt <= 1) begin
                ready_q <= 1'b1;
                data_q  <= read_line(last_addr);
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end else if (mem_req.read) begin
            // new line read, latency 1 to 4
            pending   <= 1'b1;
            wait_cnt  <= ($random(seed) & 3) + 1;
            req_count <= req_count + 1;
            last_addr <= mem_req.addr;
        end
    end

endmodule

/* logic/fetch_top.sv */
/*
 * Instruction fetch front end top level.
 * Wires the fetch unit to the instruction cache and feeds the held
 * instruction to the predecoder. Sets reset pc and cache depth.
 */
`timescale 1ns/1ps

module fetch_top #(
    parameter core_pkg::xlen_t RESET_PC  = 64'h8000_0000,
    parameter int              NUM_LINES = 16
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   dnpc_valid,
    input  core_pkg::xlen_t        dnpc,
    input  logic                   block,
    input  logic                   id_en,
    input  mem_bus_pkg::mem_resp_t mem_resp,
    output core_pkg::xlen_t        pc,
    output core_pkg::fetch_resp_t  fetch_resp,
    output core_pkg::predecode_t   predecode,
    output logic                   if_busy,
    output mem_bus_pkg::mem_req_t  mem_req
);

    // fetch unit to cache
    logic        cpu_req;
    logic        cpu_ready;
    logic        cache_idle;
    logic [63:0] cpu_line_word;

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch_unit (
        .clk           (clk),
        .rst           (rst),
        .dnpc_valid    (dnpc_valid),
        .block         (block),
        .dnpc          (dnpc),
        .id_en         (id_en),
        .cpu_ready     (cpu_ready),
        .cache_idle    (cache_idle),
        .cpu_line_word (cpu_line_word),
        .cpu_req       (cpu_req),
        .pc            (pc),
        .fetch_resp    (fetch_resp),
        .if_busy       (if_busy)
    );

    // cache looks up the current pc
    icache #(
        .NUM_LINES (NUM_LINES)
    ) u_icache (
        .clk           (clk),
        .rst           (rst),
        .cpu_req       (cpu_req),
        .cpu_addr      (pc),
        .cpu_ready     (cpu_ready),
        .cpu_line_word (cpu_line_word),
        .cache_idle    (cache_idle),
        .mem_req       (mem_req),
        .mem_resp      (mem_resp)
    );

    instr_predecode u_predecode (
        .fetch_resp (fetch_resp),
        .predecode  (predecode)
    );

endmodule

/* logic/instr_predecode.sv */
/*
 * Combinational RV64I predecoder.
 * Classifies the held instruction by its major opcode and extracts the
 * register fields and the sign-extended immediate for decode.
 */
`timescale 1ns/1ps

module instr_predecode (
    input  core_pkg::fetch_resp_t fetch_resp,
    output core_pkg::predecode_t  predecode
);
    import core_pkg::*;

    instr_t     ins;
    logic [4:0] opc;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_b;
    xlen_t      imm_u;
    xlen_t      imm_j;

    assign ins = fetch_resp.instr;
    assign opc = ins[6:2];

    // immediate formats, all sign extended from bit 31
    assign imm_i = {{52{ins[31]}}, ins[31:20]};
    assign imm_s = {{52{ins[31]}}, ins[31:25], ins[11:7]};
    assign imm_b = {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    assign imm_u = {{32{ins[31]}}, ins[31:12], 12'b0};
    assign imm_j = {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};

    always_comb begin
        predecode = '0;
        if (fetch_resp.valid) begin
            // register fields are passed raw
            predecode.rd  = ins[11:7];
            predecode.rs1 = ins[19:15];
            predecode.rs2 = ins[24:20];
            case (opc)
                OPC_OP, OPC_OP_32: begin
                    predecode.cls = CLASS_ALU;
                end
                OPC_OP_IMM, OPC_OP_IMM_32: begin
                    predecode.cls      = CLASS_ALU_IMM;
                    predecode.imm      = imm_i;
                    predecode.imm_used = 1'b1;
                end
                OPC_LUI, OPC_AUIPC: begin
                    predecode.cls      = CLASS_ALU_IMM;
                    predecode.imm      = imm_u;
                    predecode.imm_used = 1'b1;
                end
                OPC_LOAD: begin
                    predecode.cls      = CLASS_LOAD;
                    predecode.imm      = imm_i;
                    predecode.imm_used = 1'b1;
                end
                OPC_STORE: begin
                    predecode.cls      = CLASS_STORE;
                    predecode.imm      = imm_s;
                    predecode.imm_used = 1'b1;
                end
                OPC_BRANCH: begin
                    predecode.cls      = CLASS_BRANCH;
                    predecode.imm      = imm_b;
                    predecode.imm_used = 1'b1;
                end
                OPC_JAL: begin
                    predecode.cls      = CLASS_JAL;
                    predecode.imm      = imm_j;
                    predecode.imm_used = 1'b1;
                end
                OPC_JALR: begin
                    predecode.cls      = CLASS_JALR;
                    predecode.imm      = imm_i;
                    predecode.imm_used = 1'b1;
                end
                default: begin
                    // system, fence and unknown opcodes carry no immediate
                    predecode.cls = CLASS_SYSTEM_OR_ILLEGAL;
                end
            endcase
        end
    end

endmodule

/* logic/icache.sv */
/*
 * Direct-mapped read-only instruction cache.
 * Accepts a request while idle, compares the tag one cycle later and
 * answers with the 64-bit half of the line. A miss fetches the whole
 * line from the memory port, writes it and answers from the new line.
 */
`timescale 1ns/1ps

module icache #(
    parameter int NUM_LINES = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cpu_req,
    input  core_pkg::xlen_t      cpu_addr,
    output logic                 cpu_ready,
    output logic [63:0]          cpu_line_word,
    output logic                 cache_idle,
    output mem_bus_pkg::mem_req_t  mem_req,
    input  mem_bus_pkg::mem_resp_t mem_resp
);
    import core_pkg::*;
    import mem_bus_pkg::*;

    localparam int INDEX_BITS = $clog2(NUM_LINES);
    localparam int TAG_BITS   = ADDR_BITS - INDEX_BITS - OFFSET_BITS;

    typedef enum logic [1:0] {
        ST_IDLE      = 2'd0,
        ST_LOOKUP    = 2'd1,
        ST_MISS_WAIT = 2'd2,
        ST_FILL_DONE = 2'd3
    } state_e;

    state_e state;
    state_e state_next;

    // address latched on leaving idle
    xlen_t addr_q;

    // line store
    logic [NUM_LINES-1:0] valid_q;
    logic [TAG_BITS-1:0]  tag_q [NUM_LINES];
    line_t                data_q [NUM_LINES];

    logic [INDEX_BITS-1:0] index;
    logic [TAG_BITS-1:0]   tag;
    logic                  hit;
    logic                  fill_en;
    line_t                 line_rd;

    // index sits just above the byte offset, tag takes the rest
    assign index = addr_q[OFFSET_BITS +: INDEX_BITS];
    assign tag   = addr_q[ADDR_BITS-1 -: TAG_BITS];

    assign hit = valid_q[index] && (tag_q[index] == tag);

    // memory beat accepted only while waiting for it
    assign fill_en = (state == ST_MISS_WAIT) && mem_resp.ready;

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (cpu_req) begin
                    state_next = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                // a hit answers right here
                if (hit) begin
                    state_next = ST_IDLE;
                end else begin
                    state_next = ST_MISS_WAIT;
                end
            end
            ST_MISS_WAIT: begin
                if (mem_resp.ready) begin
                    state_next = ST_FILL_DONE;
                end
            end
            ST_FILL_DONE: begin
                state_next = ST_IDLE;
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    // control state
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ST_IDLE;
            valid_q <= '0;
        end else begin
            state <= state_next;
            if (fill_en) begin
                valid_q[index] <= 1'b1;
            end
        end
    end

    // sample the request address on the cycle we leave idle
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && cpu_req) begin
            addr_q <= cpu_addr;
        end
    end

    // tag and data arrays
    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_q[index]  <= tag;
            data_q[index] <= mem_resp.data;
        end
    end

    assign line_rd = data_q[index];

    // bit 3 picks the upper or lower doubleword
    assign cpu_line_word = addr_q[3] ? line_rd[LINE_BITS-1 -: 64] : line_rd[63:0];

    // one-cycle answer on hit or right after the fill
    assign cpu_ready = ((state == ST_LOOKUP) && hit) || (state == ST_FILL_DONE);

    assign cache_idle = (state == ST_IDLE);

    // read held from the miss until ready, address stays line aligned
    assign mem_req.read = ((state == ST_LOOKUP) && !hit) || (state == ST_MISS_WAIT);
    assign mem_req.addr = {addr_q[ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

endmodule

/* logic/fetch_unit.sv */
/*
 * Program counter and fetch control.
 * Issues one cache request at a time for the word at pc and holds the
 * returned instruction until decode takes it with id_en.
 */
`timescale 1ns/1ps

module fetch_unit #(
    parameter core_pkg::xlen_t RESET_PC = 64'h8000_0000
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  dnpc_valid,
    input  logic                  block,
    input  core_pkg::xlen_t       dnpc,
    input  logic                  id_en,
    input  logic                  cpu_ready,
    input  logic                  cache_idle,
    input  logic [63:0]           cpu_line_word,
    output logic                  cpu_req,
    output core_pkg::xlen_t       pc,
    output core_pkg::fetch_resp_t fetch_resp,
    output logic                  if_busy
);
    import core_pkg::*;

    logic   pc_load;
    logic   req_busy;
    logic   held;
    xlen_t  req_pc;
    xlen_t  held_pc;
    instr_t held_instr;

    // pc moves only on a next-pc strobe while not blocked
    assign pc_load = dnpc_valid && !block;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (pc_load) begin
            pc <= dnpc;
        end
    end

    // new request only when the cache is free and nothing is pending or held
    assign cpu_req = cache_idle && !req_busy && !held;

    // request outstanding flag
    always_ff @(posedge clk) begin
        if (rst) begin
            req_busy <= 1'b0;
        end else if (cpu_ready) begin
            req_busy <= 1'b0;
        end else if (cpu_req) begin
            req_busy <= 1'b1;
        end
    end

    // held flag
    // an answer cannot arrive while something is held, so ready wins
    always_ff @(posedge clk) begin
        if (rst) begin
            held <= 1'b0;
        end else if (cpu_ready) begin
            held <= 1'b1;
        end else if (id_en) begin
            held <= 1'b0;
        end
    end

    // pc of the fetch in flight, sampled with the cache
    always_ff @(posedge clk) begin
        if (cpu_req) begin
            req_pc <= pc;
        end
    end

    // pick the 32-bit half with bit 2 of the fetch pc
    always_ff @(posedge clk) begin
        if (cpu_ready) begin
            held_pc    <= req_pc;
            held_instr <= req_pc[2] ? cpu_line_word[63:32] : cpu_line_word[31:0];
        end
    end

    assign fetch_resp.valid = held;
    assign fetch_resp.pc    = held_pc;
    assign fetch_resp.instr = held_instr;

    // busy while waiting on the cache with nothing to hand over
    assign if_busy = req_busy && !held;

endmodule

/* logic/mem_bus_pkg.sv */
/*
 * Line-wide memory port types and instruction cache geometry.
 * The cache talks to external memory in whole 128-bit lines with a
 * read strobe and a ready strobe.
 */
package mem_bus_pkg;

    // one cache line is one memory beat
    localparam int LINE_BITS   = 128;
    localparam int LINE_BYTES  = LINE_BITS / 8;
    localparam int OFFSET_BITS = $clog2(LINE_BYTES);
    localparam int ADDR_BITS   = 64;

    typedef logic [LINE_BITS-1:0] line_t;

    // read request, address is line aligned
    typedef struct packed {
        logic                 read;
        logic [ADDR_BITS-1:0] addr;
    } mem_req_t;

    // ready pulses once with the whole line
    typedef struct packed {
        logic  ready;
        line_t data;
    } mem_resp_t;

endpackage

/* logic/core_pkg.sv */
/*
 * Core-wide types for the instruction fetch front end.
 * Holds the address and instruction word types, the instruction class
 * encoding, the opcode field values and the fetch and predecode records.
 * Modules import it inside their body and use scoped names in port lists.
 */
package core_pkg;

    // rv64 address and pc
    typedef logic [63:0] xlen_t;
    typedef logic [31:0] instr_t;

    // coarse instruction class handed to decode
    typedef enum logic [2:0] {
        CLASS_ALU               = 3'd0,
        CLASS_ALU_IMM           = 3'd1,
        CLASS_LOAD              = 3'd2,
        CLASS_STORE             = 3'd3,
        CLASS_BRANCH            = 3'd4,
        CLASS_JAL               = 3'd5,
        CLASS_JALR              = 3'd6,
        CLASS_SYSTEM_OR_ILLEGAL = 3'd7
    } instr_class_e;

    // major opcode, instruction bits 6:2
    localparam logic [4:0] OPC_LOAD      = 5'b00000;
    localparam logic [4:0] OPC_OP_IMM    = 5'b00100;
    localparam logic [4:0] OPC_AUIPC     = 5'b00101;
    localparam logic [4:0] OPC_OP_IMM_32 = 5'b00110;
    localparam logic [4:0] OPC_STORE     = 5'b01000;
    localparam logic [4:0] OPC_OP        = 5'b01100;
    localparam logic [4:0] OPC_LUI       = 5'b01101;
    localparam logic [4:0] OPC_OP_32     = 5'b01110;
    localparam logic [4:0] OPC_BRANCH    = 5'b11000;
    localparam logic [4:0] OPC_JALR      = 5'b11001;
    localparam logic [4:0] OPC_JAL       = 5'b11011;

    // instruction held for the decode stage
    typedef struct packed {
        logic   valid;
        xlen_t  pc;
        instr_t instr;
    } fetch_resp_t;

    // predecoder result, all zero when nothing is held
    typedef struct packed {
        instr_class_e cls;
        logic [4:0]   rd;
        logic [4:0]   rs1;
        logic [4:0]   rs2;
        xlen_t        imm;
        logic         imm_used;
    } predecode_t;

endpackage
